// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mem_server_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
logic/mem_msg_pkg.sv
logic/mem_stage_intf.sv
logic/mem_req_decode.sv
logic/mem_exec_2port.sv
logic/mem_resp_buffer.sv
logic/mem_server_2port.sv
testbench/mem_server_tb.sv

// File: logic/mem_exec_2port.sv
//----------------------------------------------------------
// Shared execute stage
// Word array and cycle counter serving both ports, with
// lane-masked writes and registered responses per port
//----------------------------------------------------------

module mem_exec_2port #(
  parameter int P_MEM_WORDS = 64
) (
  input  logic        clk,
  input  logic        rst,
  mem_stage_intf.recv in0,
  mem_stage_intf.recv in1,
  mem_stage_intf.send out0,
  mem_stage_intf.send out1
);

  localparam int WORD_BITS = $clog2(P_MEM_WORDS);

  logic [mem_msg_pkg::DATA_BITS-1:0] mem [P_MEM_WORDS];
  logic [mem_msg_pkg::DATA_BITS-1:0] cycle_count;
  logic                              fire0;
  logic                              fire1;
  logic                              wr0;
  logic                              wr1;

  assign in0.rdy = !out0.val || out0.rdy;
  assign in1.rdy = !out1.val || out1.rdy;
  assign fire0   = in0.val && in0.rdy;
  assign fire1   = in1.val && in1.rdy;

  // Only array writes touch storage
  assign wr0 = fire0 && in0.op == mem_msg_pkg::MEM_OP_WRITE &&
               in0.target == mem_msg_pkg::TARGET_ARRAY;
  assign wr1 = fire1 && in1.op == mem_msg_pkg::MEM_OP_WRITE &&
               in1.target == mem_msg_pkg::TARGET_ARRAY;

  // Response data, sampled before this edge's writes land
  function automatic logic [mem_msg_pkg::DATA_BITS-1:0] rd_data(
    input mem_msg_pkg::mem_op_e     op,
    input mem_msg_pkg::mem_target_e target,
    input logic [WORD_BITS-1:0]     word
  );
    if (op == mem_msg_pkg::MEM_OP_WRITE) begin
      return '0;
    end
    case (target)
      mem_msg_pkg::TARGET_ARRAY:   return mem[word];
      mem_msg_pkg::TARGET_COUNTER: return cycle_count;
      default:                     return '0;
    endcase
  endfunction

  //----------------------------------------------------------
  // Storage and counter
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

  // Port 1 lanes come second so they win on a shared word
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < P_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      for (int b = 0; b < mem_msg_pkg::LEN_BITS; b++) begin
        if (wr0 && in0.len[b]) begin
          mem[in0.word][8*b +: 8] <= in0.data[8*b +: 8];
        end
      end
      for (int b = 0; b < mem_msg_pkg::LEN_BITS; b++) begin
        if (wr1 && in1.len[b]) begin
          mem[in1.word][8*b +: 8] <= in1.data[8*b +: 8];
        end
      end
    end
  end

  //----------------------------------------------------------
  // Response registers
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out0.val <= 1'b0;
      out1.val <= 1'b0;
    end else begin
      if (in0.rdy) out0.val <= in0.val;
      if (in1.rdy) out1.val <= in1.val;
    end
  end

  always_ff @(posedge clk) begin
    if (fire0) begin
      out0.op     <= in0.op;
      out0.opaque <= in0.opaque;
      out0.addr   <= in0.addr;
      out0.data   <= rd_data(in0.op, in0.target, in0.word);
      out0.len    <= in0.len;
      out0.target <= in0.target;
      out0.word   <= in0.word;
    end
    if (fire1) begin
      out1.op     <= in1.op;
      out1.opaque <= in1.opaque;
      out1.addr   <= in1.addr;
      out1.data   <= rd_data(in1.op, in1.target, in1.word);
      out1.len    <= in1.len;
      out1.target <= in1.target;
      out1.word   <= in1.word;
    end
  end

  // A stalled response must survive until the buffer takes it
  out0_hold: assert property (@(posedge clk) disable iff (rst)
    out0.val && !out0.rdy |=> out0.val &&
      $stable({out0.op, out0.opaque, out0.addr, out0.data, out0.len}));

  out1_hold: assert property (@(posedge clk) disable iff (rst)
    out1.val && !out1.rdy |=> out1.val &&
      $stable({out1.op, out1.opaque, out1.addr, out1.data, out1.len}));

endmodule

// File: logic/mem_msg_pkg.sv
//----------------------------------------------------------
// Memory message definitions
// Operation and target encodings, field widths and the
// address of the cycle counter
//----------------------------------------------------------

package mem_msg_pkg;

  //----------------------------------------------------------
  // Field widths
  //----------------------------------------------------------

  localparam int OPAQUE_BITS = 8;
  localparam int LEN_BITS    = 4;
  localparam int DATA_BITS   = 32;
  localparam int ADDR_BITS   = 32;

  //----------------------------------------------------------
  // Encodings
  //----------------------------------------------------------

  // Request and response operation
  typedef enum logic {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_e;

  // Where a request lands after address decode
  typedef enum logic [1:0] {
    TARGET_ARRAY   = 2'd0,
    TARGET_COUNTER = 2'd1,
    TARGET_NONE    = 2'd2
  } mem_target_e;

  // Reads here return cycles since reset, writes are dropped
  localparam logic [ADDR_BITS-1:0] CYCLE_COUNT_ADDR = 32'hFFFF_FF00;

endpackage

// File: logic/mem_req_decode.sv
//----------------------------------------------------------
// Request decode stage
// Registers an accepted request and classifies its address
// as array word, cycle counter or nothing
//----------------------------------------------------------

module mem_req_decode #(
  parameter int P_MEM_WORDS = 64
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  mem_msg_pkg::mem_op_e                req_op,
  input  logic [mem_msg_pkg::OPAQUE_BITS-1:0] req_opaque,
  input  logic [mem_msg_pkg::ADDR_BITS-1:0]   req_addr,
  input  logic [mem_msg_pkg::DATA_BITS-1:0]   req_data,
  input  logic [mem_msg_pkg::LEN_BITS-1:0]    req_len,
  mem_stage_intf.send                         out
);

  // One byte lane per len bit
  localparam int OFFSET_BITS = $clog2(mem_msg_pkg::LEN_BITS);
  localparam int WORD_BITS   = $clog2(P_MEM_WORDS);
  localparam logic [mem_msg_pkg::ADDR_BITS-1:0] WORD_LIMIT = P_MEM_WORDS;

  logic                     req_fire;
  mem_msg_pkg::mem_target_e target_next;

  // Empty, or the held entry leaves this cycle
  assign req_rdy  = !out.val || out.rdy;
  assign req_fire = req_val && req_rdy;

  always_comb begin
    if (req_addr == mem_msg_pkg::CYCLE_COUNT_ADDR) begin
      target_next = mem_msg_pkg::TARGET_COUNTER;
    end else if ((req_addr >> OFFSET_BITS) < WORD_LIMIT) begin
      target_next = mem_msg_pkg::TARGET_ARRAY;
    end else begin
      target_next = mem_msg_pkg::TARGET_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out.val <= 1'b0;
    end else if (req_rdy) begin
      out.val <= req_val;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      out.op     <= req_op;
      out.opaque <= req_opaque;
      out.addr   <= req_addr;
      out.data   <= req_data;
      out.len    <= req_len;
      out.target <= target_next;
      out.word   <= req_addr[OFFSET_BITS +: WORD_BITS];
    end
  end

  // Requester must hold a stalled request unchanged
  req_hold_stable: assert property (@(posedge clk) disable iff (rst)
    req_val && !req_rdy |=> req_val &&
      $stable({req_op, req_opaque, req_addr, req_data, req_len}));

endmodule

// File: logic/mem_resp_buffer.sv
//----------------------------------------------------------
// Response buffer
// Circular FIFO of responses that soaks up back-pressure
// and presents its head on the response port
//----------------------------------------------------------

module mem_resp_buffer #(
  parameter int P_RESP_DEPTH = 2
) (
  input  logic                                clk,
  input  logic                                rst,
  mem_stage_intf.recv                         in,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output mem_msg_pkg::mem_op_e                resp_op,
  output logic [mem_msg_pkg::OPAQUE_BITS-1:0] resp_opaque,
  output logic [mem_msg_pkg::ADDR_BITS-1:0]   resp_addr,
  output logic [mem_msg_pkg::DATA_BITS-1:0]   resp_data,
  output logic [mem_msg_pkg::LEN_BITS-1:0]    resp_len
);

  localparam int PTR_BITS = $clog2(P_RESP_DEPTH);
  localparam int CNT_BITS = $clog2(P_RESP_DEPTH + 1);
  localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(P_RESP_DEPTH);
  localparam logic [PTR_BITS-1:0] LAST_PTR   = PTR_BITS'(P_RESP_DEPTH - 1);

  mem_msg_pkg::mem_op_e                op_q     [P_RESP_DEPTH];
  logic [mem_msg_pkg::OPAQUE_BITS-1:0] opaque_q [P_RESP_DEPTH];
  logic [mem_msg_pkg::ADDR_BITS-1:0]   addr_q   [P_RESP_DEPTH];
  logic [mem_msg_pkg::DATA_BITS-1:0]   data_q   [P_RESP_DEPTH];
  logic [mem_msg_pkg::LEN_BITS-1:0]    len_q    [P_RESP_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  assign in.rdy   = count != FULL_COUNT;
  assign push     = in.val && in.rdy;
  assign resp_val = count != '0;
  assign pop      = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]     <= in.op;
      opaque_q[wr_ptr] <= in.opaque;
      addr_q[wr_ptr]   <= in.addr;
      data_q[wr_ptr]   <= in.data;
      len_q[wr_ptr]    <= in.len;
    end
  end

  // Head of queue
  assign resp_op     = op_q[rd_ptr];
  assign resp_opaque = opaque_q[rd_ptr];
  assign resp_addr   = addr_q[rd_ptr];
  assign resp_data   = data_q[rd_ptr];
  assign resp_len    = len_q[rd_ptr];

  // A push never lands on the unread head entry
  no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> count == '0 || wr_ptr != rd_ptr);

endmodule

// File: logic/mem_server_2port.sv
//----------------------------------------------------------
// Two-port memory server
// Decode, shared execute and response buffer stages for
// two independent valid/ready request/response ports
//----------------------------------------------------------

module mem_server_2port #(
  parameter int P_MEM_WORDS  = 64,
  parameter int P_RESP_DEPTH = 2
) (
  input  logic                                clk,
  input  logic                                rst,

  // Port 0
  input  logic                                p0_req_val,
  output logic                                p0_req_rdy,
  input  mem_msg_pkg::mem_op_e                p0_req_op,
  input  logic [mem_msg_pkg::OPAQUE_BITS-1:0] p0_req_opaque,
  input  logic [mem_msg_pkg::ADDR_BITS-1:0]   p0_req_addr,
  input  logic [mem_msg_pkg::DATA_BITS-1:0]   p0_req_data,
  input  logic [mem_msg_pkg::LEN_BITS-1:0]    p0_req_len,
  output logic                                p0_resp_val,
  input  logic                                p0_resp_rdy,
  output mem_msg_pkg::mem_op_e                p0_resp_op,
  output logic [mem_msg_pkg::OPAQUE_BITS-1:0] p0_resp_opaque,
  output logic [mem_msg_pkg::ADDR_BITS-1:0]   p0_resp_addr,
  output logic [mem_msg_pkg::DATA_BITS-1:0]   p0_resp_data,
  output logic [mem_msg_pkg::LEN_BITS-1:0]    p0_resp_len,

  // Port 1
  input  logic                                p1_req_val,
  output logic                                p1_req_rdy,
  input  mem_msg_pkg::mem_op_e                p1_req_op,
  input  logic [mem_msg_pkg::OPAQUE_BITS-1:0] p1_req_opaque,
  input  logic [mem_msg_pkg::ADDR_BITS-1:0]   p1_req_addr,
  input  logic [mem_msg_pkg::DATA_BITS-1:0]   p1_req_data,
  input  logic [mem_msg_pkg::LEN_BITS-1:0]    p1_req_len,
  output logic                                p1_resp_val,
  input  logic                                p1_resp_rdy,
  output mem_msg_pkg::mem_op_e                p1_resp_op,
  output logic [mem_msg_pkg::OPAQUE_BITS-1:0] p1_resp_opaque,
  output logic [mem_msg_pkg::ADDR_BITS-1:0]   p1_resp_addr,
  output logic [mem_msg_pkg::DATA_BITS-1:0]   p1_resp_data,
  output logic [mem_msg_pkg::LEN_BITS-1:0]    p1_resp_len
);

  mem_stage_intf #(.P_MEM_WORDS(P_MEM_WORDS)) dec_if0 ();
  mem_stage_intf #(.P_MEM_WORDS(P_MEM_WORDS)) dec_if1 ();
  mem_stage_intf #(.P_MEM_WORDS(P_MEM_WORDS)) exe_if0 ();
  mem_stage_intf #(.P_MEM_WORDS(P_MEM_WORDS)) exe_if1 ();

  //----------------------------------------------------------
  // Decode
  //----------------------------------------------------------

  mem_req_decode #(.P_MEM_WORDS(P_MEM_WORDS)) dec0 (
    .clk        (clk),
    .rst        (rst),
    .req_val    (p0_req_val),
    .req_rdy    (p0_req_rdy),
    .req_op     (p0_req_op),
    .req_opaque (p0_req_opaque),
    .req_addr   (p0_req_addr),
    .req_data   (p0_req_data),
    .req_len    (p0_req_len),
    .out        (dec_if0.send)
  );

  mem_req_decode #(.P_MEM_WORDS(P_MEM_WORDS)) dec1 (
    .clk        (clk),
    .rst        (rst),
    .req_val    (p1_req_val),
    .req_rdy    (p1_req_rdy),
    .req_op     (p1_req_op),
    .req_opaque (p1_req_opaque),
    .req_addr   (p1_req_addr),
    .req_data   (p1_req_data),
    .req_len    (p1_req_len),
    .out        (dec_if1.send)
  );

  //----------------------------------------------------------
  // Execute, shared by both ports
  //----------------------------------------------------------

  mem_exec_2port #(.P_MEM_WORDS(P_MEM_WORDS)) exec (
    .clk  (clk),
    .rst  (rst),
    .in0  (dec_if0.recv),
    .in1  (dec_if1.recv),
    .out0 (exe_if0.send),
    .out1 (exe_if1.send)
  );

  //----------------------------------------------------------
  // Response buffers
  //----------------------------------------------------------

  mem_resp_buffer #(.P_RESP_DEPTH(P_RESP_DEPTH)) rsp0 (
    .clk         (clk),
    .rst         (rst),
    .in          (exe_if0.recv),
    .resp_val    (p0_resp_val),
    .resp_rdy    (p0_resp_rdy),
    .resp_op     (p0_resp_op),
    .resp_opaque (p0_resp_opaque),
    .resp_addr   (p0_resp_addr),
    .resp_data   (p0_resp_data),
    .resp_len    (p0_resp_len)
  );

  mem_resp_buffer #(.P_RESP_DEPTH(P_RESP_DEPTH)) rsp1 (
    .clk         (clk),
    .rst         (rst),
    .in          (exe_if1.recv),
    .resp_val    (p1_resp_val),
    .resp_rdy    (p1_resp_rdy),
    .resp_op     (p1_resp_op),
    .resp_opaque (p1_resp_opaque),
    .resp_addr   (p1_resp_addr),
    .resp_data   (p1_resp_data),
    .resp_len    (p1_resp_len)
  );

endmodule

// File: logic/mem_stage_intf.sv
//----------------------------------------------------------
// Stage-to-stage message channel
// One memory message with its target and word index,
// moved on a valid/ready handshake
//----------------------------------------------------------

interface mem_stage_intf #(
  parameter int P_MEM_WORDS = 64
);

  localparam int WORD_BITS = $clog2(P_MEM_WORDS);

  logic                                val;
  logic                                rdy;
  mem_msg_pkg::mem_op_e                op;
  logic [mem_msg_pkg::OPAQUE_BITS-1:0] opaque;
  logic [mem_msg_pkg::ADDR_BITS-1:0]   addr;
  logic [mem_msg_pkg::DATA_BITS-1:0]   data;
  logic [mem_msg_pkg::LEN_BITS-1:0]    len;
  mem_msg_pkg::mem_target_e            target;
  // Array index, only meaningful for TARGET_ARRAY
  logic [WORD_BITS-1:0]                word;

  modport send (
    output val, op, opaque, addr, data, len, target, word,
    input  rdy
  );

  modport recv (
    input  val, op, opaque, addr, data, len, target, word,
    output rdy
  );

endinterface

// File: testbench/mem_server_stimulus.txt
# group port op opaque addr data len expected kind
# op 0 read 1 write, kind 0 exact 1 counter increase, group and port decimal, rest hex
0 0 1 01 00000000 11111111 f 00000000 0
0 0 1 02 00000004 22222222 f 00000000 0
0 0 0 03 00000000 00000000 f 11111111 0
0 0 0 04 00000004 00000000 f 22222222 0
0 0 0 05 00000008 00000000 f 00000000 0
0 1 0 06 00000080 00000000 f 00000000 0
0 1 0 07 00000088 00000000 f 00000000 0
1 0 1 10 00000000 aabbccdd 5 00000000 0
1 0 0 11 00000000 00000000 f 11bb11dd 0
1 1 1 12 00000004 99887766 8 00000000 0
1 1 0 13 00000004 00000000 f 99222222 0
2 0 1 20 00000040 01020304 f 00000000 0
2 0 1 21 00000044 05060708 f 00000000 0
2 1 1 22 00000080 0a0b0c0d f 00000000 0
2 1 1 23 00000084 0e0f1011 f 00000000 0
3 0 0 30 00000080 00000000 f 0a0b0c0d 0
3 0 0 31 00000084 00000000 f 0e0f1011 0
3 1 0 32 00000040 00000000 f 01020304 0
3 1 0 33 00000044 00000000 f 05060708 0
4 0 0 40 ffffff00 00000000 f 00000000 1
4 0 1 41 00000200 cafef00d f 00000000 0
4 1 1 42 ffffff00 deadbeef f 00000000 0
4 1 0 43 00000100 00000000 f 00000000 0
5 0 0 50 ffffff00 00000000 f 00000000 1
5 0 0 51 00000000 00000000 f 11bb11dd 0
5 1 0 52 00000200 00000000 f 00000000 0
5 1 0 53 00000000 00000000 f 11bb11dd 0
6 0 1 60 000000c0 12345678 f 00000000 0
6 0 0 61 000000c0 00000000 f 12345678 0
6 0 1 62 000000c4 87654321 3 00000000 0
6 0 0 63 000000c4 00000000 f 00004321 0
6 1 1 64 000000e0 fedcba98 f 00000000 0
6 1 0 65 000000e0 00000000 f fedcba98 0
6 1 0 66 00000084 00000000 f 0e0f1011 0
6 1 0 67 00000004 00000000 f 99222222 0

// File: testbench/mem_server_tb.sv
//----------------------------------------------------------
// Two-port memory server testbench
// Replays the stimulus file on both ports under random
// response back-pressure and checks every response
//----------------------------------------------------------

module mem_server_tb;

  localparam int MAX_LINES   = 64;
  localparam int WAIT_CYCLES = 200;
  // Expected entry is kind, op, opaque, addr, data, len
  localparam int ENTRY_BITS  = 78;

  logic                                clk;
  logic                                rst;
  integer                              seed;

  logic                                p0_req_val;
  logic                                p0_req_rdy;
  mem_msg_pkg::mem_op_e                p0_req_op;
  logic [mem_msg_pkg::OPAQUE_BITS-1:0] p0_req_opaque;
  logic [mem_msg_pkg::ADDR_BITS-1:0]   p0_req_addr;
  logic [mem_msg_pkg::DATA_BITS-1:0]   p0_req_data;
  logic [mem_msg_pkg::LEN_BITS-1:0]    p0_req_len;
  logic                                p0_resp_val;
  logic                                p0_resp_rdy;
  mem_msg_pkg::mem_op_e                p0_resp_op;
  logic [mem_msg_pkg::OPAQUE_BITS-1:0] p0_resp_opaque;
  logic [mem_msg_pkg::ADDR_BITS-1:0]   p0_resp_addr;
  logic [mem_msg_pkg::DATA_BITS-1:0]   p0_resp_data;
  logic [mem_msg_pkg::LEN_BITS-1:0]    p0_resp_len;

  logic                                p1_req_val;
  logic                                p1_req_rdy;
  mem_msg_pkg::mem_op_e                p1_req_op;
  logic [mem_msg_pkg::OPAQUE_BITS-1:0] p1_req_opaque;
  logic [mem_msg_pkg::ADDR_BITS-1:0]   p1_req_addr;
  logic [mem_msg_pkg::DATA_BITS-1:0]   p1_req_data;
  logic [mem_msg_pkg::LEN_BITS-1:0]    p1_req_len;
  logic                                p1_resp_val;
  logic                                p1_resp_rdy;
  mem_msg_pkg::mem_op_e                p1_resp_op;
  logic [mem_msg_pkg::OPAQUE_BITS-1:0] p1_resp_opaque;
  logic [mem_msg_pkg::ADDR_BITS-1:0]   p1_resp_addr;
  logic [mem_msg_pkg::DATA_BITS-1:0]   p1_resp_data;
  logic [mem_msg_pkg::LEN_BITS-1:0]    p1_resp_len;

  // Stimulus table, one row per file line
  int          st_group  [MAX_LINES];
  int          st_port   [MAX_LINES];
  logic [31:0] st_op     [MAX_LINES];
  logic [31:0] st_opaque [MAX_LINES];
  logic [31:0] st_addr   [MAX_LINES];
  logic [31:0] st_data   [MAX_LINES];
  logic [31:0] st_len    [MAX_LINES];
  logic [31:0] st_exp    [MAX_LINES];
  logic [31:0] st_kind   [MAX_LINES];
  int          n_lines;
  int          max_group;

  logic [ENTRY_BITS-1:0] exp_q0 [$];
  logic [ENTRY_BITS-1:0] exp_q1 [$];
  logic [31:0]           last_count;

  mem_server_2port mem_server_2port_i (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //----------------------------------------------------------
  // Checking
  //----------------------------------------------------------

  task automatic fail_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_response(input int port, input logic [ENTRY_BITS-1:0] entry,
                                input logic op, input logic [7:0] opaque,
                                input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] len);
    string tag;
    tag = $sformatf("port%0d opaque %h", port, entry[75:68]);
    check_value({tag, " op"}, 32'(entry[76]), 32'(op));
    check_value({tag, " opaque"}, 32'(entry[75:68]), 32'(opaque));
    check_value({tag, " addr"}, entry[67:36], addr);
    check_value({tag, " len"}, 32'(entry[3:0]), 32'(len));
    // Counter reads only need to move forward
    if (entry[77]) begin
      check_value({tag, " counter increase"}, 32'd1, {31'd0, data > last_count});
      last_count = data;
    end else begin
      check_value({tag, " data"}, entry[35:4], data);
    end
  endtask

  always @(posedge clk) begin
    if (!rst && p0_resp_val && p0_resp_rdy) begin
      if (exp_q0.size() == 0) begin
        fail_run("port 0 returned a response that was never requested");
      end else begin
        check_response(0, exp_q0.pop_front(), p0_resp_op, p0_resp_opaque,
                       p0_resp_addr, p0_resp_data, p0_resp_len);
      end
    end
    if (!rst && p1_resp_val && p1_resp_rdy) begin
      if (exp_q1.size() == 0) begin
        fail_run("port 1 returned a response that was never requested");
      end else begin
        check_response(1, exp_q1.pop_front(), p1_resp_op, p1_resp_opaque,
                       p1_resp_addr, p1_resp_data, p1_resp_len);
      end
    end
  end

  // Random back-pressure, low on roughly a third of cycles
  always @(posedge clk) begin
    p0_resp_rdy <= ({$random(seed)} % 3) != 0;
    p1_resp_rdy <= ({$random(seed)} % 3) != 0;
  end

  //----------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------

  task automatic read_stimulus();
    int    fd;
    int    n;
    string line;
    fd = $fopen("testbench/mem_server_stimulus.txt", "r");
    if (fd == 0) fail_run("the stimulus file could not be opened");
    while ($fgets(line, fd) != 0) begin
      if (n_lines >= MAX_LINES) fail_run("the stimulus file has too many lines");
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%d %d %h %h %h %h %h %h %d", st_group[n_lines],
                    st_port[n_lines], st_op[n_lines], st_opaque[n_lines],
                    st_addr[n_lines], st_data[n_lines], st_len[n_lines],
                    st_exp[n_lines], st_kind[n_lines]);
        if (n == 9) begin
          if (st_group[n_lines] > max_group) max_group = st_group[n_lines];
          n_lines++;
        end
      end
    end
    $fclose(fd);
    if (n_lines == 0) fail_run("the stimulus file holds no requests");
  endtask

  function automatic logic [ENTRY_BITS-1:0] make_entry(input int idx);
    return {st_kind[idx][0], st_op[idx][0], st_opaque[idx][7:0], st_addr[idx],
            st_exp[idx], st_len[idx][3:0]};
  endfunction

  task automatic drive_port(input int port, input bit active, input int idx);
    if (port == 0) begin
      p0_req_val    <= active;
      p0_req_op     <= mem_msg_pkg::mem_op_e'(st_op[idx][0]);
      p0_req_opaque <= st_opaque[idx][7:0];
      p0_req_addr   <= st_addr[idx];
      p0_req_data   <= st_data[idx];
      p0_req_len    <= st_len[idx][3:0];
    end else begin
      p1_req_val    <= active;
      p1_req_op     <= mem_msg_pkg::mem_op_e'(st_op[idx][0]);
      p1_req_opaque <= st_opaque[idx][7:0];
      p1_req_addr   <= st_addr[idx];
      p1_req_data   <= st_data[idx];
      p1_req_len    <= st_len[idx][3:0];
    end
  endtask

  // Issue one group on both ports, then drain its responses
  task automatic run_group(input int g);
    int q0 [$];
    int q1 [$];
    int cycles;
    for (int i = 0; i < n_lines; i++) begin
      if (st_group[i] == g && st_port[i] == 0) q0.push_back(i);
      if (st_group[i] == g && st_port[i] != 0) q1.push_back(i);
    end
    drive_port(0, q0.size() > 0, (q0.size() > 0) ? q0[0] : 0);
    drive_port(1, q1.size() > 0, (q1.size() > 0) ? q1[0] : 0);
    cycles = 0;
    while (q0.size() > 0 || q1.size() > 0) begin
      @(posedge clk);
      if (p0_req_val && p0_req_rdy) exp_q0.push_back(make_entry(q0.pop_front()));
      if (p1_req_val && p1_req_rdy) exp_q1.push_back(make_entry(q1.pop_front()));
      drive_port(0, q0.size() > 0, (q0.size() > 0) ? q0[0] : 0);
      drive_port(1, q1.size() > 0, (q1.size() > 0) ? q1[0] : 0);
      cycles++;
      if (cycles > WAIT_CYCLES) fail_run($sformatf("group %0d requests were not accepted", g));
    end
    cycles = 0;
    while (exp_q0.size() > 0 || exp_q1.size() > 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_CYCLES) fail_run($sformatf("group %0d responses went missing", g));
    end
  endtask

  initial begin
    seed          = 32'hc5c7_abfb;
    rst           = 1'b1;
    n_lines       = 0;
    max_group     = 0;
    last_count    = '0;
    p0_req_val    = 1'b0;
    p0_req_op     = mem_msg_pkg::MEM_OP_READ;
    p0_req_opaque = '0;
    p0_req_addr   = '0;
    p0_req_data   = '0;
    p0_req_len    = '0;
    p0_resp_rdy   = 1'b0;
    p1_req_val    = 1'b0;
    p1_req_op     = mem_msg_pkg::MEM_OP_READ;
    p1_req_opaque = '0;
    p1_req_addr   = '0;
    p1_req_data   = '0;
    p1_req_len    = '0;
    p1_resp_rdy   = 1'b0;
    read_stimulus();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int g = 0; g <= max_group; g++) begin
      run_group(g);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule
